// File: common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Bus and storage word width in bits.
`define WORD_BITS 32

// RAM size in bytes. A power of two, so byte addresses wrap on the low bits.
`define MEM_BYTES 16384

// Byte address of the first IO register.
`define IO_BASE 10240

// Number of IO registers. The window ends just below IO_BASE + 4 * IO_WORDS.
`define IO_WORDS 8

`endif

// File: common/mem_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    //////////////////////////////
    // Storage and bus words
    //////////////////////////////

    typedef union packed {
        logic [`WORD_BITS-1:0]          word;   // Whole word.
        logic [`WORD_BITS/8-1:0][7:0]   bytes;  // Byte lanes with lane 0 in bits 7:0.
    } mem_word_u;

    //////////////////////////////
    // Data port
    //////////////////////////////

    typedef struct packed {
        logic                           valid;
        logic                           write;
        logic [`WORD_BITS-1:0]          addr;   // Byte address.
        logic [`WORD_BITS-1:0]          wdata;  // Little-endian bus order.
        logic [`WORD_BITS/8-1:0]        be;     // One enable per bus byte.
    } data_req_t;

    typedef struct packed {
        logic [`WORD_BITS-1:0]          rdata;
        logic                           ready;  // Write accepted at this edge.
    } data_rsp_t;

endpackage

`default_nettype wire

// File: memory/mem_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_array (
    input  logic                            clk,
    input  logic [$clog2(`MEM_BYTES)-3:0]   i_word,
    output mem_pkg::mem_word_u              inst_raw,
    input  logic [$clog2(`MEM_BYTES)-3:0]   d_word,
    output mem_pkg::mem_word_u              d_raw,
    input  logic                            wen,
    input  mem_pkg::mem_word_u              wword
);

    localparam int DEPTH = `MEM_BYTES / 4;

    // Every word is kept byte-reversed, as in a big-endian hex image.
    mem_pkg::mem_word_u mem [DEPTH];

    //////////////////////////////
    // Instruction read port
    //////////////////////////////

    always_ff @(posedge clk) begin
        inst_raw <= mem[i_word];
    end

    //////////////////////////////
    // Data read and write port
    //////////////////////////////

    // The read returns the old word when it hits the word being written,
    // which is what the partial write merge relies on.
    always_ff @(posedge clk) begin
        d_raw <= mem[d_word];
        if (wen) begin
            mem[d_word] <= wword;
        end
    end

endmodule

`default_nettype wire

// File: memory/io_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module io_window (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [$clog2(`IO_WORDS)-1:0]    index,
    output mem_pkg::mem_word_u              rdata,
    input  logic                            wen,
    input  mem_pkg::mem_word_u              wword
);

    localparam int MSG_LEN = 6;
    localparam logic [8*MSG_LEN-1:0] MSG = "HELLO\n";

    mem_pkg::mem_word_u regs [`IO_WORDS];

    //////////////////////////////
    // Register bank
    //////////////////////////////

    // Reset loads a length word followed by one character per word. Each
    // value sits in the top lane, the first byte of the stored image.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `IO_WORDS; i++) begin
                regs[i] <= '0;
            end
            regs[0].bytes[3] <= 8'(MSG_LEN);
            for (int i = 0; i < MSG_LEN; i++) begin
                regs[i + 1].bytes[3] <= MSG[8*(MSG_LEN-1-i) +: 8];
            end
        end else if (wen) begin
            regs[index] <= wword;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    always_ff @(posedge clk) begin
        rdata <= regs[index];  // Same latency as the RAM data port.
    end

endmodule

`default_nettype wire

// File: memory/data_port_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module data_port_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  mem_pkg::data_req_t              d_req,
    output mem_pkg::data_rsp_t              d_rsp,
    output logic [$clog2(`MEM_BYTES)-3:0]   ram_word,
    input  mem_pkg::mem_word_u              ram_rd,
    output logic                            ram_wen,
    output logic [$clog2(`IO_WORDS)-1:0]    io_index,
    input  mem_pkg::mem_word_u              io_rd,
    output logic                            io_wen,
    output mem_pkg::mem_word_u              wword
);

    localparam int ADDR_BITS = $clog2(`MEM_BYTES);
    localparam int IDX_BITS  = $clog2(`IO_WORDS);
    localparam int NBYTES    = `WORD_BITS / 8;

    localparam logic [ADDR_BITS-1:0] IO_LO = ADDR_BITS'(`IO_BASE);
    localparam logic [ADDR_BITS-1:0] IO_HI = ADDR_BITS'(`IO_BASE + 4 * `IO_WORDS);

    logic [ADDR_BITS-1:0]   byte_addr;
    logic [ADDR_BITS-1:0]   io_offset;
    logic                   in_io;
    logic                   io_sel_q;
    logic                   wr_req;
    logic                   full_be;
    logic                   armed;
    logic                   ready;
    mem_pkg::mem_word_u     old_word;
    mem_pkg::mem_word_u     new_word;

    // Converts between bus order and stored order in either direction.
    function automatic mem_pkg::mem_word_u swap_lanes(input mem_pkg::mem_word_u w);
        mem_pkg::mem_word_u s;
        for (int i = 0; i < NBYTES; i++) begin
            s.bytes[i] = w.bytes[NBYTES-1-i];
        end
        return s;
    endfunction

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign byte_addr = d_req.addr[ADDR_BITS-1:0];  // Wraps modulo the RAM size.
    assign io_offset = byte_addr - IO_LO;
    assign in_io     = (byte_addr >= IO_LO) && (byte_addr < IO_HI);
    assign ram_word  = byte_addr[ADDR_BITS-1:2];
    assign io_index  = io_offset[IDX_BITS+1:2];

    // Read data arrives a cycle later, so the select has to follow it.
    always_ff @(posedge clk) begin
        if (reset) begin
            io_sel_q <= 1'b0;
        end else begin
            io_sel_q <= in_io;
        end
    end

    //////////////////////////////
    // Write sequencer
    //////////////////////////////

    assign wr_req  = d_req.valid && d_req.write;
    assign full_be = &d_req.be;
    assign ready   = wr_req && (full_be || armed);

    // A partial write spends one cycle armed while the old word is read,
    // then commits. Dropping the request or committing returns to idle.
    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b0;
        end else begin
            armed <= wr_req && !full_be && !armed;
        end
    end

    //////////////////////////////
    // Data path
    //////////////////////////////

    always_comb begin
        old_word = swap_lanes(io_sel_q ? io_rd : ram_rd);
        for (int i = 0; i < NBYTES; i++) begin
            new_word.bytes[i] = d_req.be[i] ? d_req.wdata[8*i +: 8] : old_word.bytes[i];
        end
    end

    assign wword   = swap_lanes(new_word);
    assign ram_wen = ready && !in_io;
    assign io_wen  = ready && in_io;

    assign d_rsp.rdata = old_word.word;
    assign d_rsp.ready = ready;

endmodule

`default_nettype wire

// File: rtl/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`WORD_BITS-1:0]   i_addr,
    output logic [`WORD_BITS-1:0]   inst,
    input  mem_pkg::data_req_t      d_req,
    output mem_pkg::data_rsp_t      d_rsp
);

    logic [$clog2(`MEM_BYTES)-3:0]  ram_word;
    mem_pkg::mem_word_u             ram_rd;
    logic                           ram_wen;
    logic [$clog2(`IO_WORDS)-1:0]   io_index;
    mem_pkg::mem_word_u             io_rd;
    logic                           io_wen;
    mem_pkg::mem_word_u             wword;

    data_port_ctrl ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .d_req      (d_req),
        .d_rsp      (d_rsp),
        .ram_word   (ram_word),
        .ram_rd     (ram_rd),
        .ram_wen    (ram_wen),
        .io_index   (io_index),
        .io_rd      (io_rd),
        .io_wen     (io_wen),
        .wword      (wword)
    );

    mem_array ram_i (
        .clk        (clk),
        .i_word     (i_addr[$clog2(`MEM_BYTES)-1:2]),
        .inst_raw   ({inst[7:0], inst[15:8], inst[23:16], inst[31:24]}),  // To bus order.
        .d_word     (ram_word),
        .d_raw      (ram_rd),
        .wen        (ram_wen),
        .wword      (wword)
    );

    io_window io_i (
        .clk        (clk),
        .reset      (reset),
        .index      (io_index),
        .rdata      (io_rd),
        .wen        (io_wen),
        .wword      (wword)
    );

endmodule

`default_nettype wire

// File: verification/mem_subsystem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_sva (
    input logic                 clk,
    input logic                 reset,
    input mem_pkg::data_req_t   d_req,
    input mem_pkg::data_rsp_t   d_rsp
);

    logic wr_req;
    logic partial;

    assign wr_req  = d_req.valid && d_req.write;
    assign partial = wr_req && !(&d_req.be);  // Needs the read-modify-write path.

    ready_needs_write: assert property (@(posedge clk) disable iff (reset)
        d_rsp.ready |-> wr_req)
        else $error("ready is high without a valid write");

    partial_first_cycle: assert property (@(posedge clk) disable iff (reset)
        $rose(partial) |-> !d_rsp.ready)
        else $error("partial write accepted in its first cycle");

    partial_ready_next: assert property (@(posedge clk) disable iff (reset)
        partial && !d_rsp.ready |=> d_rsp.ready)
        else $error("partial write not accepted one cycle after it appeared");

    ready_low_after_reset: assert property (@(posedge clk)
        reset |=> !d_rsp.ready)
        else $error("ready is high in the cycle after reset");

endmodule

bind data_port_ctrl mem_subsystem_sva sva_i (
    .clk    (clk),
    .reset  (reset),
    .d_req  (d_req),
    .d_rsp  (d_rsp)
);

`default_nettype wire

// File: verification/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_ROWS     = 128;
    localparam int NRAND        = 16;
    localparam int WAIT_LIMIT   = 8;
    localparam int RAM_AW       = $clog2(`MEM_BYTES) - 2;
    localparam int IO_AW        = $clog2(`IO_WORDS);
    localparam logic [31:0] PARTIAL_BE = 32'hEA53_8421;  // One nibble per partial write.

    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_FETCH = 2'd2;

    typedef struct packed {
        logic [1:0]     op;
        logic [31:0]    addr;
        logic [31:0]    wdata;
        logic [3:0]     be;
        logic [31:0]    exp_val;
    } row_t;

    logic               clk;
    logic               reset;
    logic [31:0]        i_addr;
    logic [31:0]        inst;
    mem_pkg::data_req_t d_req;
    mem_pkg::data_rsp_t d_rsp;

    row_t               rows [MAX_ROWS];
    int                 n_rows;
    int                 errors;
    logic [31:0]        lcg_state;
    logic [31:0]        model_ram [2**RAM_AW];  // Bus order.
    logic [31:0]        model_io [`IO_WORDS];

    mem_subsystem dut_i (
        .clk    (clk),
        .reset  (reset),
        .i_addr (i_addr),
        .inst   (inst),
        .d_req  (d_req),
        .d_rsp  (d_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        int unsigned a;
        a = addr % `MEM_BYTES;
        return (a >= `IO_BASE) && (a < `IO_BASE + 4 * `IO_WORDS);  // End is exclusive.
    endfunction

    function automatic logic [RAM_AW-1:0] ram_index(input logic [31:0] addr);
        return RAM_AW'((addr % `MEM_BYTES) / 4);
    endfunction

    function automatic logic [IO_AW-1:0] io_index(input logic [31:0] addr);
        return IO_AW'(((addr % `MEM_BYTES) - `IO_BASE) / 4);
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (in_window(addr)) begin
            return model_io[io_index(addr)];
        end
        return model_ram[ram_index(addr)];
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] be);
        logic [31:0] merged;
        merged = model_read(addr);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        if (in_window(addr)) begin
            model_io[io_index(addr)] = merged;
        end else begin
            model_ram[ram_index(addr)] = merged;
        end
    endfunction

    function automatic void add_row(input logic [1:0] op, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] exp_val;
        exp_val = '0;
        if (op == OP_WRITE) begin
            model_write(addr, wdata, be);
        end else if (op == OP_FETCH) begin
            exp_val = model_ram[ram_index(addr)];  // The fetch port never sees IO.
        end else begin
            exp_val = model_read(addr);
        end
        if (n_rows < MAX_ROWS) begin
            rows[n_rows] = '{op, addr, wdata, be, exp_val};
            n_rows++;
        end else begin
            errors++;
            $display("Stimulus table is full, a row was dropped");
        end
    endfunction

    function automatic void build_table();
        logic [31:0] addr_list [NRAND];
        for (int i = 0; i < 7; i++) begin
            add_row(OP_READ, `IO_BASE + 4 * i, '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(OP_WRITE, 32'(4 * i), lcg_next(), 4'hF);
        end
        for (int i = 0; i < NRAND; i++) begin
            addr_list[i] = lcg_next() & 32'h0000_1FFC;  // Always below the IO window.
            add_row(OP_WRITE, addr_list[i], lcg_next(), 4'hF);
        end
        for (int i = 0; i < NRAND; i++) begin
            add_row(OP_READ, addr_list[i], '0, '0);
        end
        for (int i = 0; i < NRAND; i++) begin
            add_row(OP_FETCH, addr_list[i], '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(OP_WRITE, addr_list[i], lcg_next(), PARTIAL_BE[4*i +: 4]);
            add_row(OP_READ, addr_list[i], '0, '0);
        end
        add_row(OP_READ, addr_list[0] + `MEM_BYTES, '0, '0);
        add_row(OP_WRITE, addr_list[1] + 2 * `MEM_BYTES, lcg_next(), 4'hF);
        add_row(OP_READ, addr_list[1], '0, '0);
        add_row(OP_FETCH, addr_list[1] + `MEM_BYTES, '0, '0);
        add_row(OP_WRITE, `IO_BASE + 28, lcg_next(), 4'hF);
        add_row(OP_WRITE, `IO_BASE + 28 + `MEM_BYTES, lcg_next(), 4'h6);
        add_row(OP_READ, `IO_BASE + 28, '0, '0);
        add_row(OP_READ, 32'd28, '0, '0);
        add_row(OP_FETCH, 32'd28, '0, '0);
        add_row(OP_WRITE, `IO_BASE + 32, lcg_next(), 4'hF);  // First word past the window.
        add_row(OP_READ, `IO_BASE + 32, '0, '0);
        add_row(OP_FETCH, `IO_BASE + 32, '0, '0);
    endfunction

    //////////////////////////////
    // Bus tasks
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        assert (got === exp_val) else begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp_val);
        end
    endtask

    task automatic drive_req(input logic valid, input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
        d_req.valid = valid;
        d_req.write = write;
        d_req.addr  = addr;
        d_req.wdata = wdata;
        d_req.be    = be;
    endtask

    task automatic write_row(input row_t row);
        int waited;
        waited = 0;
        drive_req(1'b1, 1'b1, row.addr, row.wdata, row.be);
        @(negedge clk);
        while (!d_rsp.ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        assert (d_rsp.ready) else begin
            errors++;
            $display("Write to address %h was not accepted within %0d cycles",
                     row.addr, WAIT_LIMIT);
        end
        @(posedge clk);
        #1;
        drive_req(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic read_row(input row_t row);
        drive_req(1'b1, 1'b0, row.addr, '0, '0);
        @(posedge clk);
        #1;
        check_value("d_rsp.rdata", d_rsp.rdata, row.exp_val);
    endtask

    task automatic fetch_row(input row_t row);
        i_addr = row.addr;
        @(posedge clk);
        #1;
        check_value("inst", inst, row.exp_val);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset     = 1'b1;
        i_addr    = '0;
        d_req     = '0;
        errors    = 0;
        n_rows    = 0;
        lcg_state = 32'h00909585;
        model_io  = '{32'd6, 32'h48, 32'h45, 32'h4C, 32'h4C, 32'h4F, 32'h0A, 32'h0};
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            case (rows[r].op)
                OP_WRITE: write_row(rows[r]);
                OP_FETCH: fetch_row(rows[r]);
                default:  read_row(rows[r]);
            endcase
        end
        $display("Rows applied: %0d, errors: %0d", n_rows, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Ten cycles for each row of the table.
    initial begin
        wait (n_rows > 0);
        repeat (RESET_CYCLES + n_rows * 10) @(posedge clk);
        $display("Timeout: the stimulus table did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/mem_pkg.sv
memory/mem_array.sv
memory/io_window.sv
memory/data_port_ctrl.sv
rtl/mem_subsystem.sv
verification/mem_subsystem_sva.sv
verification/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
